// ==== source/fp_mult_consts.svh ====
`ifndef FP_MULT_CONSTS_SVH
`define FP_MULT_CONSTS_SVH

// Single precision word layout
`define FP_WIDTH 32
`define EXP_WIDTH 8
`define MAN_WIDTH 23

`define EXP_BIAS 127

// Significand carries the hidden one
`define SIG_WIDTH (`MAN_WIDTH + 1)

// Full significand product before normalization
`define PROD_WIDTH (2 * `SIG_WIDTH)

`endif

// ==== source/fp_mult_pkg.sv ====
`include "fp_mult_consts.svh"

package fp_mult_pkg;

	// Field view of a single precision word
	typedef struct packed
	{
		logic                  sign;
		logic [`EXP_WIDTH-1:0] exp;
		logic [`MAN_WIDTH-1:0] frac;
	} fp_fields_s;

	// Same bits seen as a raw word or as fields
	typedef union packed
	{
		logic [`FP_WIDTH-1:0] word;
		fp_fields_s           fields;
	} fp_word_u;

endpackage

// ==== source/fsm_mult_function.sv ====
`timescale 1ns/1ps

module fsm_mult_function (
	input  logic       clk,
	input  logic       rst,
	input  logic       beg_i,
	input  logic       ack_i,
	input  logic       zero_flag_i,
	input  logic       mult_shift_i,
	input  logic       round_flag_i,
	input  logic       add_overflow_i,
	output logic       load_0_o,
	output logic       load_1_o,
	output logic       load_2_o,
	output logic       load_3_o,
	output logic       load_4_o,
	output logic       load_5_o,
	output logic       load_6_o,
	output logic       ctrl_select_a_o,
	output logic [1:0] selector_b_o,
	output logic       exp_op_o,
	output logic       shift_value_o,
	output logic       ctrl_select_c_o,
	output logic       rst_int_o,
	output logic       ready_o
);

	localparam logic [3:0] st_idle       = 4'd0;
	localparam logic [3:0] st_load_ops   = 4'd1;
	localparam logic [3:0] st_extra      = 4'd2;
	localparam logic [3:0] st_add_exp    = 4'd3;
	localparam logic [3:0] st_subt_bias  = 4'd4;
	localparam logic [3:0] st_mult_ovf   = 4'd5;
	localparam logic [3:0] st_norm_shift = 4'd6;
	localparam logic [3:0] st_norm       = 4'd7;
	localparam logic [3:0] st_round_case = 4'd8;
	localparam logic [3:0] st_round_add  = 4'd9;
	localparam logic [3:0] st_round_norm = 4'd10;
	localparam logic [3:0] st_final      = 4'd11;
	localparam logic [3:0] st_ready      = 4'd12;

	logic [3:0] state_q;
	logic [3:0] state_d;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state_q <= st_idle;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		load_0_o = 1'b0;
		load_1_o = 1'b0;
		load_2_o = 1'b0;
		load_3_o = 1'b0;
		load_4_o = 1'b0;
		load_5_o = 1'b0;
		load_6_o = 1'b0;
		ctrl_select_a_o = 1'b0;
		selector_b_o = 2'b00;
		exp_op_o = 1'b0;
		shift_value_o = 1'b0;
		ctrl_select_c_o = 1'b0;
		rst_int_o = 1'b0;
		ready_o = 1'b0;

		case (state_q)
			st_idle:
			begin
				rst_int_o = 1'b1;
				if (beg_i)
					state_d = st_load_ops;
			end
			st_load_ops:
			begin
				load_0_o = 1'b1;
				state_d = st_extra;
			end
			// Multiplier settles from the fresh significands
			st_extra:
				state_d = st_add_exp;
			st_add_exp:
			begin
				load_1_o = 1'b1;
				load_2_o = 1'b1;
				load_4_o = 1'b1;
				ctrl_select_a_o = 1'b1;
				selector_b_o = 2'b01;
				state_d = st_subt_bias;
			end
			st_subt_bias:
			begin
				load_2_o = 1'b1;
				exp_op_o = 1'b1;
				if (zero_flag_i)
					state_d = st_ready;
				else
					state_d = st_mult_ovf;
			end
			st_mult_ovf:
			begin
				if (mult_shift_i)
					state_d = st_norm_shift;
				else
					state_d = st_norm;
			end
			// Product in [2,4) takes the upper slice and bumps the exponent
			st_norm_shift:
			begin
				shift_value_o = 1'b1;
				load_6_o = 1'b1;
				load_2_o = 1'b1;
				selector_b_o = 2'b10;
				state_d = st_round_case;
			end
			st_norm:
			begin
				load_6_o = 1'b1;
				state_d = st_round_case;
			end
			st_round_case:
			begin
				if (round_flag_i)
					state_d = st_round_add;
				else
					state_d = st_final;
			end
			st_round_add:
			begin
				load_5_o = 1'b1;
				state_d = st_round_norm;
			end
			st_round_norm:
			begin
				load_6_o = 1'b1;
				ctrl_select_c_o = 1'b1;
				if (add_overflow_i)
				begin
					shift_value_o = 1'b1;
					load_2_o = 1'b1;
					selector_b_o = 2'b10;
				end
				state_d = st_final;
			end
			st_final:
			begin
				load_3_o = 1'b1;
				state_d = st_ready;
			end
			st_ready:
			begin
				ready_o = 1'b1;
				if (ack_i)
					state_d = st_idle;
			end
			default:
				state_d = st_idle;
		endcase
	end

	// Code 11 selects nothing in the exponent adder
	assert property (@(posedge clk) disable iff (rst) selector_b_o != 2'b11);

	// Datapath must be frozen while the result is offered
	assert property (@(posedge clk) disable iff (rst)
		ready_o |-> !(load_0_o || load_1_o || load_2_o || load_3_o ||
			load_4_o || load_5_o || load_6_o));

endmodule

// ==== source/exp_sign_path.sv ====
`timescale 1ns/1ps
`include "fp_mult_consts.svh"

module exp_sign_path (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rst_int_i,
	input  logic                  load_0_i,
	input  logic                  load_1_i,
	input  logic                  load_2_i,
	input  logic                  load_3_i,
	input  logic                  ctrl_select_a_i,
	input  logic [1:0]            selector_b_i,
	input  logic                  exp_op_i,
	input  fp_mult_pkg::fp_word_u op_a_i,
	input  fp_mult_pkg::fp_word_u op_b_i,
	input  logic [`MAN_WIDTH-1:0] frac_i,
	output logic                  zero_flag_o,
	output fp_mult_pkg::fp_word_u result_o
);
	import fp_mult_pkg::*;

	// Two spare bits hold the sum of two biased exponents
	localparam int exp_w = `EXP_WIDTH + 2;

	logic [`EXP_WIDTH-1:0] exp_a_q;
	logic [`EXP_WIDTH-1:0] exp_b_q;
	logic                  sign_a_q;
	logic                  sign_b_q;
	logic                  sign_q;
	logic [exp_w-1:0]      exp_q;
	logic [exp_w-1:0]      add_a;
	logic [exp_w-1:0]      add_b;
	logic [exp_w-1:0]      add_res;
	fp_word_u              result_q;

	always_ff @(posedge clk)
	begin
		if (rst_int_i)
		begin
			exp_a_q <= '0;
			exp_b_q <= '0;
			sign_a_q <= 1'b0;
			sign_b_q <= 1'b0;
			sign_q <= 1'b0;
			exp_q <= '0;
		end
		else
		begin
			if (load_0_i)
			begin
				exp_a_q <= op_a_i.fields.exp;
				exp_b_q <= op_b_i.fields.exp;
				sign_a_q <= op_a_i.fields.sign;
				sign_b_q <= op_b_i.fields.sign;
			end
			if (load_1_i)
				sign_q <= sign_a_q ^ sign_b_q;
			if (load_2_i)
				exp_q <= add_res;
		end
	end

	// Shared adder takes operand a or the running exponent on A
	assign add_a = ctrl_select_a_i ? exp_w'(exp_a_q) : exp_q;

	always_comb
	begin
		case (selector_b_i)
			2'b00:   add_b = exp_w'(`EXP_BIAS);
			2'b01:   add_b = exp_w'(exp_b_q);
			2'b10:   add_b = exp_w'(1);
			default: add_b = '0;
		endcase
	end

	assign add_res = exp_op_i ? add_a - add_b : add_a + add_b;

	assign zero_flag_o = (exp_a_q == '0) || (exp_b_q == '0);

	// Zero operands leave the cleared result in place
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			result_q <= '0;
		else if (rst_int_i)
			result_q <= '0;
		else if (load_3_i)
		begin
			result_q.fields.sign <= sign_q;
			result_q.fields.exp <= exp_q[`EXP_WIDTH-1:0];
			result_q.fields.frac <= frac_i;
		end
	end

	assign result_o = result_q;

	assert property (@(posedge clk) disable iff (rst) load_3_i |-> !zero_flag_o);

endmodule

// ==== source/sig_mult.sv ====
`timescale 1ns/1ps
`include "fp_mult_consts.svh"

module sig_mult (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rst_int_i,
	input  logic                   load_0_i,
	input  logic                   load_4_i,
	input  fp_mult_pkg::fp_word_u  op_a_i,
	input  fp_mult_pkg::fp_word_u  op_b_i,
	output logic [`PROD_WIDTH-1:0] product_o,
	output logic                   mult_shift_o
);

	localparam int sig_w = `SIG_WIDTH;
	localparam int prod_w = `PROD_WIDTH;

	logic [sig_w-1:0]  sig_a_q;
	logic [sig_w-1:0]  sig_b_q;
	logic [prod_w-1:0] prod_q;

	// Hidden one goes in front of each fraction
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sig_a_q <= '0;
			sig_b_q <= '0;
		end
		else if (rst_int_i)
		begin
			sig_a_q <= '0;
			sig_b_q <= '0;
		end
		else if (load_0_i)
		begin
			sig_a_q <= {1'b1, op_a_i.fields.frac};
			sig_b_q <= {1'b1, op_b_i.fields.frac};
		end
	end

	// Multiplier has a spare cycle before this register loads
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			prod_q <= '0;
		else if (rst_int_i)
			prod_q <= '0;
		else if (load_4_i)
			prod_q <= prod_w'(sig_a_q) * prod_w'(sig_b_q);
	end

	assign product_o = prod_q;

	// Product of two [1,2) values reached [2,4)
	assign mult_shift_o = prod_q[prod_w-1];

endmodule

// ==== source/round_norm.sv ====
`timescale 1ns/1ps
`include "fp_mult_consts.svh"

module round_norm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rst_int_i,
	input  logic                   load_5_i,
	input  logic                   load_6_i,
	input  logic                   shift_value_i,
	input  logic                   ctrl_select_c_i,
	input  logic [`PROD_WIDTH-1:0] product_i,
	output logic                   round_flag_o,
	output logic                   add_overflow_o,
	output logic [`MAN_WIDTH-1:0]  frac_o
);

	localparam int sig_w = `SIG_WIDTH;
	localparam int prod_w = `PROD_WIDTH;

	logic [sig_w-1:0] slice;
	logic             guard;
	logic             sticky;
	logic [sig_w-1:0] sig_q;
	logic             guard_q;
	logic             sticky_q;
	logic [sig_w:0]   sum_q;

	always_comb
	begin
		if (shift_value_i)
		begin
			slice = product_i[prod_w-1 -: sig_w];
			guard = product_i[prod_w-sig_w-1];
			sticky = |product_i[prod_w-sig_w-2:0];
		end
		else
		begin
			slice = product_i[prod_w-2 -: sig_w];
			guard = product_i[prod_w-sig_w-2];
			sticky = |product_i[prod_w-sig_w-3:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_int_i)
		begin
			sig_q <= '0;
			guard_q <= 1'b0;
			sticky_q <= 1'b0;
			sum_q <= '0;
		end
		else
		begin
			if (load_6_i)
			begin
				// Rounded value has no bits left below the LSB
				if (ctrl_select_c_i)
				begin
					sig_q <= shift_value_i ? sum_q[sig_w:1] : sum_q[sig_w-1:0];
					guard_q <= 1'b0;
					sticky_q <= 1'b0;
				end
				else
				begin
					sig_q <= slice;
					guard_q <= guard;
					sticky_q <= sticky;
				end
			end
			if (load_5_i)
				sum_q <= {1'b0, sig_q} + 1'b1;
		end
	end

	// Nearest, ties to even
	assign round_flag_o = guard_q & (sticky_q | sig_q[0]);
	assign add_overflow_o = sum_q[sig_w];
	assign frac_o = sig_q[`MAN_WIDTH-1:0];

	assert property (@(posedge clk) disable iff (rst) load_6_i |=> sig_q[sig_w-1]);

endmodule

// ==== source/fp_mult_top.sv ====
`timescale 1ns/1ps
`include "fp_mult_consts.svh"

module fp_mult_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 beg_i,
	input  logic                 ack_i,
	input  logic [`FP_WIDTH-1:0] op_a_i,
	input  logic [`FP_WIDTH-1:0] op_b_i,
	output logic                 ready_o,
	output logic [`FP_WIDTH-1:0] result_o
);
	import fp_mult_pkg::*;

	fp_word_u               op_a_w;
	fp_word_u               op_b_w;
	fp_word_u               result_w;
	logic                   load_0;
	logic                   load_1;
	logic                   load_2;
	logic                   load_3;
	logic                   load_4;
	logic                   load_5;
	logic                   load_6;
	logic                   ctrl_select_a;
	logic [1:0]             selector_b;
	logic                   exp_op;
	logic                   shift_value;
	logic                   ctrl_select_c;
	logic                   rst_int;
	logic                   zero_flag;
	logic                   mult_shift;
	logic                   round_flag;
	logic                   add_overflow;
	logic [`PROD_WIDTH-1:0] product;
	logic [`MAN_WIDTH-1:0]  frac;

	assign op_a_w.word = op_a_i;
	assign op_b_w.word = op_b_i;
	assign result_o = result_w.word;

	fsm_mult_function u_fsm (
		.clk(clk), .rst(rst), .beg_i(beg_i), .ack_i(ack_i),
		.zero_flag_i(zero_flag), .mult_shift_i(mult_shift),
		.round_flag_i(round_flag), .add_overflow_i(add_overflow),
		.load_0_o(load_0), .load_1_o(load_1), .load_2_o(load_2), .load_3_o(load_3),
		.load_4_o(load_4), .load_5_o(load_5), .load_6_o(load_6),
		.ctrl_select_a_o(ctrl_select_a), .selector_b_o(selector_b), .exp_op_o(exp_op),
		.shift_value_o(shift_value), .ctrl_select_c_o(ctrl_select_c),
		.rst_int_o(rst_int), .ready_o(ready_o)
	);

	exp_sign_path u_exp_sign_path (
		.clk(clk), .rst(rst), .rst_int_i(rst_int),
		.load_0_i(load_0), .load_1_i(load_1), .load_2_i(load_2), .load_3_i(load_3),
		.ctrl_select_a_i(ctrl_select_a), .selector_b_i(selector_b), .exp_op_i(exp_op),
		.op_a_i(op_a_w), .op_b_i(op_b_w), .frac_i(frac),
		.zero_flag_o(zero_flag), .result_o(result_w)
	);

	sig_mult u_sig_mult (
		.clk(clk), .rst(rst), .rst_int_i(rst_int),
		.load_0_i(load_0), .load_4_i(load_4),
		.op_a_i(op_a_w), .op_b_i(op_b_w),
		.product_o(product), .mult_shift_o(mult_shift)
	);

	round_norm u_round_norm (
		.clk(clk), .rst(rst), .rst_int_i(rst_int),
		.load_5_i(load_5), .load_6_i(load_6),
		.shift_value_i(shift_value), .ctrl_select_c_i(ctrl_select_c),
		.product_i(product), .round_flag_o(round_flag),
		.add_overflow_o(add_overflow), .frac_o(frac)
	);

endmodule

// ==== test/tb_fp_mult_top.sv ====
`timescale 1ns/1ps
`include "fp_mult_consts.svh"

module tb_fp_mult_top;

	localparam int num_vec = 15;
	localparam int timeout_cycles = num_vec * 20 + 100;
	// Longest path from the beg_i pulse to ready_o
	localparam int max_latency = 12;

	// Columns are operand a, operand b, expected product
	localparam logic [3*`FP_WIDTH-1:0] vectors [num_vec] = '{
		{32'h3FC0_0000, 32'h3FA0_0000, 32'h3FF0_0000},
		{32'h4000_0000, 32'h4040_0000, 32'h40C0_0000},
		{32'hC000_0000, 32'h4040_0000, 32'hC0C0_0000},
		{32'hBFC0_0000, 32'hBFA0_0000, 32'h3FF0_0000},
		{32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000},
		{32'hBFC0_0000, 32'h3FC0_0000, 32'hC010_0000},
		{32'h3F00_0000, 32'h4100_0000, 32'h4080_0000},
		{32'h3FFF_FFFF, 32'h3F80_0001, 32'h4000_0000},
		// Tie with odd LSB rounds up and carries out to 2.0
		{32'h3F84_2108, 32'h3FF8_0000, 32'h4000_0000},
		{32'h3FC0_0001, 32'h3FC0_0001, 32'h4010_0002},
		{32'h3F80_0001, 32'h4040_0000, 32'h4040_0002},
		{32'h3F80_0003, 32'h4040_0000, 32'h4040_0004},
		{32'h0000_0000, 32'h3FC0_0000, 32'h0000_0000},
		{32'h8000_0000, 32'hC000_0000, 32'h0000_0000},
		{32'h3FC0_0000, 32'h0040_0000, 32'h0000_0000}
	};

	logic                 clk;
	logic                 rst;
	logic                 beg_i;
	logic                 ack_i;
	logic [`FP_WIDTH-1:0] op_a_i;
	logic [`FP_WIDTH-1:0] op_b_i;
	logic                 ready_o;
	logic [`FP_WIDTH-1:0] result_o;

	int                   errors = 0;
	int                   checks = 0;
	int                   cycles = 0;
	int                   hold;
	bit                   seen;

	fp_mult_top u_fp_mult_top (
		.clk(clk), .rst(rst), .beg_i(beg_i), .ack_i(ack_i),
		.op_a_i(op_a_i), .op_b_i(op_b_i),
		.ready_o(ready_o), .result_o(result_o)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > timeout_cycles)
		begin
			$display("Timeout: run went past %0d cycles", timeout_cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [`FP_WIDTH-1:0] got,
		input logic [`FP_WIDTH-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Starts on a falling edge and returns one cycle after the beg_i pulse
	task automatic start_op(input logic [`FP_WIDTH-1:0] a, input logic [`FP_WIDTH-1:0] b);
		op_a_i = a;
		op_b_i = b;
		beg_i = 1'b1;
		@(negedge clk);
		beg_i = 1'b0;
	endtask

	task automatic wait_ready(output bit found);
		int n;
		n = 1;
		while (!ready_o && n < max_latency)
		begin
			@(negedge clk);
			n++;
		end
		found = ready_o;
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		beg_i = 1'b0;
		ack_i = 1'b0;
		op_a_i = '0;
		op_b_i = '0;
		void'($urandom(32'hd3e7_3c4e));

		repeat (5) @(negedge clk);
		rst = 1'b0;

		check_value("ready_o", {31'b0, ready_o}, 32'h0);
		check_value("result_o", result_o, 32'h0);
		repeat (4) @(negedge clk);
		check_value("ready_o", {31'b0, ready_o}, 32'h0);

		for (int i = 0; i < num_vec; i++)
		begin
			start_op(vectors[i][95:64], vectors[i][63:32]);
			wait_ready(seen);
			checks++;
			assert (seen)
			else
			begin
				errors++;
				$display("Vector %0d: ready_o did not rise within %0d cycles", i, max_latency);
			end
			check_value("result_o", result_o, vectors[i][31:0]);

			// A second beg_i while the result waits must change nothing
			hold = int'($urandom_range(6, 3));
			for (int k = 0; k < hold; k++)
			begin
				beg_i = (k == 0);
				@(negedge clk);
				check_value("ready_o", {31'b0, ready_o}, 32'h1);
				check_value("result_o", result_o, vectors[i][31:0]);
			end
			beg_i = 1'b0;

			ack_i = 1'b1;
			@(negedge clk);
			ack_i = 1'b0;
			check_value("ready_o", {31'b0, ready_o}, 32'h0);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+source
source/fp_mult_pkg.sv
source/fsm_mult_function.sv
source/exp_sign_path.sv
source/sig_mult.sv
source/round_norm.sv
source/fp_mult_top.sv
test/tb_fp_mult_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_fp_mult_top
FILELIST  := all.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test failures found
SOURCES   := $(shell grep -v '^+' $(FILELIST)) source/fp_mult_consts.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
